// ==== Makefile ====
SRCS := $(shell grep -v '^+' build.f) include/alloc_model.svh

obj_dir/Vtb_comb_nonspec_allocator: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module tb_comb_nonspec_allocator

run: obj_dir/Vtb_comb_nonspec_allocator
	obj_dir/Vtb_comb_nonspec_allocator

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== build.f ====
+incdir+include
hw/noc_alloc_pkg.sv
hw/rr_arbiter.sv
hw/ovc_candidate_select.sv
hw/nonspec_sw_alloc.sv
hw/ovc_grant_route.sv
hw/comb_nonspec_allocator.sv
tb/tb_comb_nonspec_allocator.sv

// ==== hw/comb_nonspec_allocator.sv ====
`timescale 1ns/10ps
`default_nettype none

module comb_nonspec_allocator
    import noc_alloc_pkg::*;
#(
    parameter int V = default_v,
    parameter int P = default_p
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [P*V-1:0]       ivc_request,
    input  logic [P*V-1:0]       ovc_is_assigned,
    input  logic [P*V-1:0]       assigned_ovc_not_full,
    input  logic [P*V*V-1:0]     masked_ovc_request,
    input  logic [P*V*(P-1)-1:0] dest_port,
    output logic [P*(P-1)-1:0]   granted_dest_port,
    output logic [P*V-1:0]       ivc_sw_grant,
    output logic [P-1:0]         any_ivc_granted,
    output logic [P-1:0]         any_outport_granted,
    output logic [P*V-1:0]       granted_ovc,
    output logic [P*V-1:0]       ivc_ovc_grant,
    output logic [P*V-1:0]       ovc_allocated
);

    logic [P*V*V-1:0] candidate_ovc;        // one ovc per ivc
    logic [P*V-1:0]   ivc_request_masked;
    logic [P*V-1:0]   first_grant;          // input arbiter winners

    ovc_candidate_select #(
        .V (V),
        .P (P)
    ) i_cand (
        .clk                   (clk),
        .arst_n                (arst_n),
        .ivc_request           (ivc_request),
        .ovc_is_assigned       (ovc_is_assigned),
        .assigned_ovc_not_full (assigned_ovc_not_full),
        .ivc_ovc_grant         (ivc_ovc_grant),
        .masked_ovc_request    (masked_ovc_request),
        .candidate_ovc         (candidate_ovc),
        .ivc_request_masked    (ivc_request_masked)
    );

    nonspec_sw_alloc #(
        .V (V),
        .P (P)
    ) i_sw_alloc (
        .clk                 (clk),
        .arst_n              (arst_n),
        .ivc_request_masked  (ivc_request_masked),
        .dest_port           (dest_port),
        .first_grant         (first_grant),
        .ivc_sw_grant        (ivc_sw_grant),
        .granted_dest_port   (granted_dest_port),
        .any_ivc_granted     (any_ivc_granted),
        .any_outport_granted (any_outport_granted)
    );

    // closes the loop back to the ovc arbiters
    ovc_grant_route #(
        .V (V),
        .P (P)
    ) i_grant_route (
        .candidate_ovc     (candidate_ovc),
        .first_grant       (first_grant),
        .granted_dest_port (granted_dest_port),
        .any_ivc_granted   (any_ivc_granted),
        .granted_ovc       (granted_ovc),
        .ivc_ovc_grant     (ivc_ovc_grant),
        .ovc_allocated     (ovc_allocated)
    );

endmodule

`default_nettype wire

// ==== hw/noc_alloc_pkg.sv ====
`default_nettype none

package noc_alloc_pkg;

    localparam int default_v = 4;   // vcs per port
    localparam int default_p = 5;   // router ports

    // widest select and slice the mux helper handles
    localparam int sel_max   = 32;
    localparam int slice_max = 32;
    localparam int data_max  = sel_max * slice_max;

    // one-hot mux: slice s of data is kept when sel[s] is set, all kept slices ORed
    function automatic logic [slice_max-1:0] onehot_select(
        input logic [data_max-1:0] data,
        input logic [sel_max-1:0]  sel,
        input int unsigned         count,
        input int unsigned         width
    );
        logic [slice_max-1:0] result;
        result = '0;
        for (int unsigned s = 0; s < count; s++) begin
            for (int unsigned b = 0; b < width; b++) begin
                result[b] = result[b] | (data[s*width+b] & sel[s]);
            end
        end
        return result;
    endfunction

    // position of other_port in the P-1 wide vector seen from self_port
    function automatic int unsigned local_port_index(
        input int unsigned self_port,
        input int unsigned other_port
    );
        if (other_port < self_port) begin
            return other_port;
        end
        return other_port - 1;   // own index is skipped
    endfunction

endpackage

`default_nettype wire

// ==== hw/nonspec_sw_alloc.sv ====
`timescale 1ns/10ps
`default_nettype none

module nonspec_sw_alloc
    import noc_alloc_pkg::*;
#(
    parameter int V = 4,
    parameter int P = 5
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [P*V-1:0]       ivc_request_masked,
    input  logic [P*V*(P-1)-1:0] dest_port,
    output logic [P*V-1:0]       first_grant,
    output logic [P*V-1:0]       ivc_sw_grant,
    output logic [P*(P-1)-1:0]   granted_dest_port,
    output logic [P-1:0]         any_ivc_granted,
    output logic [P-1:0]         any_outport_granted
);

    localparam int vp_1 = V * (P - 1);

    logic [V-1:0]         in_grant  [P];   // first level winners
    logic [slice_max-1:0] dest_wide [P];
    logic [P-2:0]         dest_sel  [P];   // destination of each winner
    logic [P-2:0]         out_grant [P];

    // regrouped per output port, filled bit by bit below
    wire  [P-2:0]         out_req   [P];
    wire  [P-2:0]         gdp       [P];   // granted destination per input

    for (genvar i = 0; i < P; i++) begin : g_in
        // input arbiter keeps its priority until the port wins an output
        rr_arbiter #(
            .WIDTH       (V),
            .EXT_ADVANCE (1)
        ) i_in_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (ivc_request_masked[i*V +: V]),
            .advance   (any_ivc_granted[i]),
            .grant     (in_grant[i]),
            .any_grant ()
        );

        assign dest_wide[i] = onehot_select(data_max'(dest_port[i*vp_1 +: vp_1]),
                                            sel_max'(in_grant[i]), V, P - 1);
        assign dest_sel[i]  = dest_wide[i][P-2:0];

        assign any_ivc_granted[i]           = |gdp[i];
        assign first_grant[i*V +: V]        = in_grant[i];
        assign ivc_sw_grant[i*V +: V]       = any_ivc_granted[i] ? in_grant[i] : '0;
        assign granted_dest_port[i*(P-1) +: P-1] = gdp[i];
    end

    // i is the output port, j the input port
    for (genvar i = 0; i < P; i++) begin : g_out
        for (genvar j = 0; j < P; j++) begin : g_src
            if (j != i) begin : g_link
                localparam int unsigned out_pos = local_port_index(i, j);
                localparam int unsigned in_pos  = local_port_index(j, i);

                assign out_req[i][out_pos] = dest_sel[j][in_pos];
                assign gdp[j][in_pos]      = out_grant[i][out_pos];  // grant back
            end
        end

        rr_arbiter #(
            .WIDTH       (P - 1),
            .EXT_ADVANCE (0)
        ) i_out_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (out_req[i]),
            .advance   (1'b1),
            .grant     (out_grant[i]),
            .any_grant (any_outport_granted[i])
        );

        // one input per output, and an input only wins where its winner was headed
        assert property (@(posedge clk) disable iff (!arst_n)
            $onehot0(out_grant[i]) && ((gdp[i] & ~dest_sel[i]) == '0))
            else $error("nonspec_sw_alloc: port %0d grant %b dest %b",
                        i, out_grant[i], dest_sel[i]);
    end

endmodule

`default_nettype wire

// ==== hw/ovc_candidate_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module ovc_candidate_select #(
    parameter int V = 4,
    parameter int P = 5
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [P*V-1:0]   ivc_request,
    input  logic [P*V-1:0]   ovc_is_assigned,
    input  logic [P*V-1:0]   assigned_ovc_not_full,
    input  logic [P*V-1:0]   ivc_ovc_grant,
    input  logic [P*V*V-1:0] masked_ovc_request,
    output logic [P*V*V-1:0] candidate_ovc,
    output logic [P*V-1:0]   ivc_request_masked
);

    logic [P*V-1:0] assigned_ready;   // owns an ovc with room left
    logic [P*V-1:0] ovc_offered;      // at least one free ovc on offer

    assign assigned_ready = ivc_request & ovc_is_assigned & assigned_ovc_not_full;

    // a full assigned ovc simply drops out here
    assign ivc_request_masked = assigned_ready | ovc_offered;

    // one ovc arbiter per ivc, moves only when its ivc really gets the ovc
    for (genvar k = 0; k < P*V; k++) begin : g_ivc
        rr_arbiter #(
            .WIDTH       (V),
            .EXT_ADVANCE (1)
        ) i_ovc_arb (
            .clk       (clk),
            .arst_n    (arst_n),
            .request   (masked_ovc_request[k*V +: V]),
            .advance   (ivc_ovc_grant[k]),
            .grant     (candidate_ovc[k*V +: V]),
            .any_grant (ovc_offered[k])
        );
    end

endmodule

`default_nettype wire

// ==== hw/ovc_grant_route.sv ====
`timescale 1ns/10ps
`default_nettype none

module ovc_grant_route
    import noc_alloc_pkg::*;
#(
    parameter int V = 4,
    parameter int P = 5
) (
    input  logic [P*V*V-1:0]   candidate_ovc,
    input  logic [P*V-1:0]     first_grant,
    input  logic [P*(P-1)-1:0] granted_dest_port,
    input  logic [P-1:0]       any_ivc_granted,
    output logic [P*V-1:0]     granted_ovc,
    output logic [P*V-1:0]     ivc_ovc_grant,
    output logic [P*V-1:0]     ovc_allocated
);

    localparam int vv = V * V;

    logic [slice_max-1:0] cand_wide [P];
    logic [V-1:0]         cand      [P];   // candidate ovc of the port's winner
    logic [P-1:0]         cand_valid;

    // per output vc, one bit per other input port
    wire  [P-2:0]         alloc_src [P*V];

    for (genvar i = 0; i < P; i++) begin : g_in
        assign cand_wide[i] = onehot_select(data_max'(candidate_ovc[i*vv +: vv]),
                                            sel_max'(first_grant[i*V +: V]), V, V);
        assign cand[i]       = cand_wide[i][V-1:0];
        assign cand_valid[i] = |cand[i];

        assign granted_ovc[i*V +: V] = any_ivc_granted[i] ? cand[i] : '0;

        // an ivc already holding its ovc has no candidate and gets no ovc grant
        assign ivc_ovc_grant[i*V +: V] = (any_ivc_granted[i] && cand_valid[i]) ?
                                         first_grant[i*V +: V] : '0;
    end

    // spread each candidate over the output its port won
    for (genvar o = 0; o < P; o++) begin : g_out
        for (genvar i = 0; i < P; i++) begin : g_src
            if (i != o) begin : g_link
                localparam int unsigned out_pos = local_port_index(o, i);
                localparam int unsigned in_pos  = local_port_index(i, o);

                for (genvar v = 0; v < V; v++) begin : g_vc
                    assign alloc_src[o*V+v][out_pos] =
                        cand[i][v] & granted_dest_port[i*(P-1) + in_pos];
                end
            end
        end
    end

    for (genvar k = 0; k < P*V; k++) begin : g_ovc
        assign ovc_allocated[k] = |alloc_src[k];

        // two inputs never take the same output vc in one cycle
        always_comb begin
            assert final ($onehot0(alloc_src[k]))
                else $error("ovc_grant_route: ovc %0d taken by %b", k, alloc_src[k]);
        end
    end

endmodule

`default_nettype wire

// ==== hw/rr_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
    parameter int WIDTH       = 4,
    parameter int EXT_ADVANCE = 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] request,
    input  logic             advance,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    // msb after reset, so bit 0 goes first
    localparam logic [WIDTH-1:0] ptr_reset = WIDTH'(1) << (WIDTH - 1);

    logic [WIDTH-1:0] pointer;     // one-hot, last winner
    logic [WIDTH-1:0] above;       // bits strictly above the pointer
    logic [WIDTH-1:0] req_above;
    logic [WIDTH-1:0] pick;
    logic             step;

    always_comb begin
        above[0] = 1'b0;
        for (int b = 1; b < WIDTH; b++) begin
            above[b] = above[b-1] | pointer[b-1];
        end
    end

    assign req_above = request & above;
    assign pick      = (|req_above) ? req_above : request;  // wrap to bit 0
    assign grant     = pick & (~pick + 1'b1);               // lowest set bit
    assign any_grant = |request;

    // output arbiters move on every grant
    assign step = (EXT_ADVANCE != 0) ? advance : 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pointer <= ptr_reset;
        end else if (step && any_grant) begin
            pointer <= grant;
        end
    end

    // winner is at most one line and always one that asked
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(grant) && ((grant & ~request) == '0))
        else $error("rr_arbiter: grant %b for request %b", grant, request);

endmodule

`default_nettype wire

// ==== include/alloc_model.svh ====
`ifndef ALLOC_MODEL_SVH
`define ALLOC_MODEL_SVH

// reference model that needs V, P and noc_alloc_pkg visible where it is included
logic [V-1:0]       m_ovc_ptr [P*V];     // one-hot like the rtl pointers
logic [V-1:0]       m_in_ptr  [P];
logic [P-2:0]       m_out_ptr [P];
logic [V-1:0]       m_cand    [P*V];
logic [V-1:0]       m_in_grant [P];
logic [P-2:0]       m_out_grant [P];
logic [P*(P-1)-1:0] m_granted_dest_port;
logic [P*V-1:0]     m_ivc_sw_grant;
logic [P*V-1:0]     m_granted_ovc;
logic [P*V-1:0]     m_ivc_ovc_grant;
logic [P*V-1:0]     m_ovc_allocated;
logic [P-1:0]       m_any_ivc_granted;
logic [P-1:0]       m_any_outport_granted;

// first request found cyclically above the pointer
function automatic logic [31:0] rr_pick(input logic [31:0] req, input logic [31:0] ptr,
                                        input int width);
    int unsigned start;
    int unsigned idx;
    rr_pick = '0;
    start = 0;
    for (int b = 0; b < width; b++) begin
        if (ptr[b]) start = b;
    end
    for (int k = 1; k <= width; k++) begin
        idx = (start + k) % width;
        if (req[idx] && rr_pick == '0) rr_pick[idx] = 1'b1;
    end
endfunction

task automatic clear_model_pointers();
    foreach (m_ovc_ptr[k]) m_ovc_ptr[k] = V'(1) << (V - 1);
    foreach (m_in_ptr[p]) m_in_ptr[p] = V'(1) << (V - 1);
    foreach (m_out_ptr[o]) m_out_ptr[o] = (P-1)'(1) << (P - 2);
endtask

task automatic predict_outputs(input logic [P*V-1:0] req, input logic [P*V-1:0] assigned,
                               input logic [P*V-1:0] not_full, input logic [P*V*V-1:0] offer,
                               input logic [P*V*(P-1)-1:0] dest);
    logic [V-1:0] swreq;
    logic [P-2:0] dsel [P];
    logic [P-2:0] oreq;
    logic [V-1:0] win_cand;
    int unsigned  k;
    m_granted_dest_port = '0;
    m_any_ivc_granted = '0;
    {m_ivc_sw_grant, m_granted_ovc, m_ivc_ovc_grant, m_ovc_allocated} = '0;
    for (int p = 0; p < P; p++) begin
        dsel[p] = '0;
        for (int v = 0; v < V; v++) begin
            k = p * V + v;
            m_cand[k] = V'(rr_pick(32'(offer[k*V +: V]), 32'(m_ovc_ptr[k]), V));
            swreq[v] = (req[k] & assigned[k] & not_full[k]) | (|offer[k*V +: V]);
        end
        m_in_grant[p] = V'(rr_pick(32'(swreq), 32'(m_in_ptr[p]), V));
        for (int v = 0; v < V; v++) begin
            if (m_in_grant[p][v]) dsel[p] = dest[(p*V+v)*(P-1) +: P-1];
        end
    end
    for (int o = 0; o < P; o++) begin
        oreq = '0;
        for (int i = 0; i < P; i++) begin
            if (i != o) oreq[local_port_index(o, i)] = dsel[i][local_port_index(i, o)];
        end
        m_out_grant[o] = (P-1)'(rr_pick(32'(oreq), 32'(m_out_ptr[o]), P - 1));
        m_any_outport_granted[o] = |oreq;
        for (int i = 0; i < P; i++) begin
            if (i != o && m_out_grant[o][local_port_index(o, i)]) begin
                m_granted_dest_port[i*(P-1) + local_port_index(i, o)] = 1'b1;
                m_any_ivc_granted[i] = 1'b1;
            end
        end
    end
    for (int p = 0; p < P; p++) begin
        win_cand = '0;
        for (int v = 0; v < V; v++) begin
            if (m_in_grant[p][v]) win_cand = m_cand[p*V+v];
        end
        if (m_any_ivc_granted[p]) begin
            m_ivc_sw_grant[p*V +: V] = m_in_grant[p];
            m_granted_ovc[p*V +: V] = win_cand;
            if (|win_cand) m_ivc_ovc_grant[p*V +: V] = m_in_grant[p];
            for (int o = 0; o < P; o++) begin
                if (o != p && m_granted_dest_port[p*(P-1) + local_port_index(p, o)]) begin
                    m_ovc_allocated[o*V +: V] = m_ovc_allocated[o*V +: V] | win_cand;
                end
            end
        end
    end
endtask

// pointers move after predict_outputs with the same rules as the rtl arbiters
task automatic advance_model_pointers();
    for (int k = 0; k < P*V; k++) begin
        if (m_ivc_ovc_grant[k] && m_cand[k] != '0) m_ovc_ptr[k] = m_cand[k];
    end
    for (int p = 0; p < P; p++) begin
        if (m_any_ivc_granted[p] && m_in_grant[p] != '0) m_in_ptr[p] = m_in_grant[p];
        if (m_out_grant[p] != '0) m_out_ptr[p] = m_out_grant[p];
    end
endtask

`endif

// ==== tb/tb_comb_nonspec_allocator.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_comb_nonspec_allocator
    import noc_alloc_pkg::*;
();

    localparam int V = default_v;
    localparam int P = default_p;
    localparam int random_cycles   = 2000;
    localparam int directed_cycles = 40;   // reset, idle and the three directed cases
    localparam int timeout_ns      = (random_cycles + directed_cycles) * 10 * 2;

    logic                 clk;
    logic                 arst_n;
    logic [P*V-1:0]       ivc_request;
    logic [P*V-1:0]       ovc_is_assigned;
    logic [P*V-1:0]       assigned_ovc_not_full;
    logic [P*V*V-1:0]     masked_ovc_request;
    logic [P*V*(P-1)-1:0] dest_port;
    logic [P*(P-1)-1:0]   granted_dest_port;
    logic [P*V-1:0]       ivc_sw_grant;
    logic [P-1:0]         any_ivc_granted;
    logic [P-1:0]         any_outport_granted;
    logic [P*V-1:0]       granted_ovc;
    logic [P*V-1:0]       ivc_ovc_grant;
    logic [P*V-1:0]       ovc_allocated;
    logic [31:0]          lfsr;

    `include "alloc_model.svh"

    comb_nonspec_allocator #(.V(V), .P(P)) i_dut (.*);

    always #5 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int n = 0; n < count; n++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // real port number behind position idx of self's other-port vector
    function automatic int unsigned port_from_index(input int unsigned self_port,
                                                    input int unsigned idx);
        return (idx < self_port) ? idx : idx + 1;
    endfunction

    task automatic check_value(input string test_name, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("error: %s %s expected %h actual %h", test_name, field, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic settle_and_compare(input string test_name);
        #4;   // 1 ns before the rising edge
        predict_outputs(ivc_request, ovc_is_assigned, assigned_ovc_not_full,
                        masked_ovc_request, dest_port);
        check_value(test_name, "granted_dest_port", 64'(m_granted_dest_port),
                    64'(granted_dest_port));
        check_value(test_name, "ivc_sw_grant", 64'(m_ivc_sw_grant), 64'(ivc_sw_grant));
        check_value(test_name, "any_ivc_granted", 64'(m_any_ivc_granted), 64'(any_ivc_granted));
        check_value(test_name, "any_outport_granted", 64'(m_any_outport_granted),
                    64'(any_outport_granted));
        check_value(test_name, "granted_ovc", 64'(m_granted_ovc), 64'(granted_ovc));
        check_value(test_name, "ivc_ovc_grant", 64'(m_ivc_ovc_grant), 64'(ivc_ovc_grant));
        check_value(test_name, "ovc_allocated", 64'(m_ovc_allocated), 64'(ovc_allocated));
    endtask

    task automatic advance_clock();
        @(posedge clk);
        advance_model_pointers();
        @(negedge clk);
    endtask

    task automatic clear_inputs();
        ivc_request           = '0;
        ovc_is_assigned       = '0;
        assigned_ovc_not_full = '0;
        masked_ovc_request    = '0;
        dest_port             = '0;
    endtask

    task automatic random_traffic(input int cycles);
        logic [31:0] bits;
        int unsigned target [P*V];   // output port each ivc heads for
        int unsigned idx;
        int unsigned k;
        logic        chosen;
        for (int c = 0; c < cycles; c++) begin
            clear_inputs();
            for (int n = 0; n < P*V; n++) begin
                take_bits(3, bits);
                ivc_request[n]           = bits[0];
                ovc_is_assigned[n]       = bits[1];
                assigned_ovc_not_full[n] = bits[2];
                take_bits(8, bits);
                idx = bits % (P - 1);
                dest_port[n*(P-1) + idx] = 1'b1;
                target[n] = port_from_index(n / V, idx);
            end
            // each free ovc goes to at most one unassigned ivc heading there
            for (int o = 0; o < P; o++) begin
                for (int v = 0; v < V; v++) begin
                    take_bits(9, bits);
                    chosen = ~bits[8];
                    for (int s = 0; s < P*V; s++) begin
                        k = (bits[7:0] + s) % (P*V);
                        if (!chosen && ivc_request[k] && !ovc_is_assigned[k] && target[k] == o) begin
                            masked_ovc_request[k*V + v] = 1'b1;
                            chosen = 1'b1;
                        end
                    end
                end
            end
            settle_and_compare("random traffic");
            advance_clock();
        end
    endtask

    initial begin
        #(timeout_ns);
        $display("timeout: allocator run still going after %0d ns", timeout_ns);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        lfsr   = 32'h905d9283;
        clear_inputs();
        clear_model_pointers();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        repeat (3) begin
            settle_and_compare("idle");
            check_value("idle", "any grant", 64'(0),
                        64'(|{ivc_sw_grant, granted_dest_port, granted_ovc, ivc_ovc_grant,
                              ovc_allocated, any_ivc_granted, any_outport_granted}));
            advance_clock();
        end

        // ivc 2 of port 1 toward port 3 with ovcs 1 and 3 free there
        ivc_request[1*V+2] = 1'b1;
        dest_port[(1*V+2)*(P-1) + 2] = 1'b1;
        masked_ovc_request[(1*V+2)*V +: V] = 4'b1010;
        settle_and_compare("lone request");
        check_value("lone request", "ivc_sw_grant", 64'(1) << (1*V+2), 64'(ivc_sw_grant));
        check_value("lone request", "granted_dest_port", 64'(1) << (1*(P-1)+2),
                    64'(granted_dest_port));
        check_value("lone request", "granted_ovc", 64'(4'b0010) << (1*V), 64'(granted_ovc));
        check_value("lone request", "ovc_allocated", 64'(1) << (3*V+1), 64'(ovc_allocated));
        advance_clock();
        clear_inputs();

        // all ivcs of port 0 hold ready ovcs at port 2
        ivc_request[V-1:0]           = '1;
        ovc_is_assigned[V-1:0]       = '1;
        assigned_ovc_not_full[V-1:0] = '1;
        for (int v = 0; v < V; v++) dest_port[v*(P-1) + 1] = 1'b1;
        for (int r = 0; r < V; r++) begin
            settle_and_compare("round robin");
            check_value("round robin", "ivc_sw_grant", 64'(1) << r, 64'(ivc_sw_grant));
            advance_clock();
        end
        clear_inputs();

        // ivc 1 of port 4 owns a full ovc at port 0
        ivc_request[4*V+1]     = 1'b1;
        ovc_is_assigned[4*V+1] = 1'b1;
        dest_port[(4*V+1)*(P-1)] = 1'b1;
        repeat (2) begin
            settle_and_compare("assigned ovc full");
            check_value("assigned ovc full", "ivc_sw_grant", 64'(0), 64'(ivc_sw_grant));
            advance_clock();
        end
        assigned_ovc_not_full[4*V+1] = 1'b1;
        settle_and_compare("assigned ovc ready");
        check_value("assigned ovc ready", "ivc_sw_grant", 64'(1) << (4*V+1), 64'(ivc_sw_grant));
        check_value("assigned ovc ready", "ivc_ovc_grant", 64'(0), 64'(ivc_ovc_grant));
        advance_clock();

        random_traffic(random_cycles);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
